// File: verilog/bitGenPkg.sv
// Bit generator constants
`default_nettype none

package bitGenPkg;

	// Widths and tile geometry
	localparam int countWidth = 16;
	localparam int tileShift = 2;
	localparam int pixelPosWidth = 4;
	localparam int colorWidth = 8;
	localparam int shapeWidth = 3;

	// Solid squares
	localparam logic [countWidth-1:0] glyphBlack = 16'd0;
	localparam logic [countWidth-1:0] glyphBlue = 16'd1;
	localparam logic [countWidth-1:0] glyphYellow = 16'd2;
	localparam logic [countWidth-1:0] glyphWhite = 16'd53;

	// Path glyph ranges, seven shapes per team
	localparam logic [countWidth-1:0] bluePathFirst = 16'd3;
	localparam logic [countWidth-1:0] bluePathLast = 16'd9;
	localparam logic [countWidth-1:0] yellowPathFirst = 16'd28;
	localparam logic [countWidth-1:0] yellowPathLast = 16'd34;

	// Shape index is the offset from the start of the range
	localparam logic [shapeWidth-1:0] shapeHorizontal = 3'd0;
	localparam logic [shapeWidth-1:0] shapeVertical = 3'd1;
	localparam logic [shapeWidth-1:0] shapeCorner = 3'd2;
	localparam logic [shapeWidth-1:0] shapeLeftDown = 3'd3;
	localparam logic [shapeWidth-1:0] shapeLeftUp = 3'd4;
	localparam logic [shapeWidth-1:0] shapeRightDown = 3'd5;
	localparam logic [shapeWidth-1:0] shapeRightUp = 3'd6;

	localparam logic [1:0] solidBlack = 2'd0;
	localparam logic [1:0] solidBlue = 2'd1;
	localparam logic [1:0] solidYellow = 2'd2;
	localparam logic [1:0] solidWhite = 2'd3;

	// Palette as {R, G, B}
	localparam logic [3*colorWidth-1:0] blueEdge = {8'd0, 8'd162, 8'd230};
	localparam logic [3*colorWidth-1:0] blueInner = {8'd156, 8'd219, 8'd230};
	localparam logic [3*colorWidth-1:0] yellowEdge = {8'd255, 8'd201, 8'd14};
	localparam logic [3*colorWidth-1:0] yellowInner = {8'd255, 8'd254, 8'd145};
	localparam logic [3*colorWidth-1:0] pureBlue = {8'd0, 8'd0, 8'd255};
	localparam logic [3*colorWidth-1:0] pureYellow = {8'd255, 8'd255, 8'd0};
	localparam logic [3*colorWidth-1:0] white = {8'd255, 8'd255, 8'd255};

endpackage

`default_nettype wire

// File: verilog/tileFetch.sv
// Tile address and offset pipeline
`default_nettype none

module tileFetch #(
	parameter int tileMapBase = 40000,
	parameter int tilesPerRow = 160
) (
	input wire clk,
	input wire reset,
	input wire [bitGenPkg::countWidth-1:0] hCount,
	input wire [bitGenPkg::countWidth-1:0] vCount,
	input wire bright,
	output logic [bitGenPkg::countWidth-1:0] memAddress,
	output logic [bitGenPkg::pixelPosWidth-1:0] pixelPos,
	output logic brightDelayed
);
	import bitGenPkg::*;

	localparam logic [countWidth-1:0] baseWord = countWidth'(tileMapBase);
	localparam logic [countWidth-1:0] rowStride = countWidth'(tilesPerRow);

	logic [countWidth-1:0] tileCol;
	logic [countWidth-1:0] tileRow;
	logic [pixelPosWidth-1:0] pixelPosNext;

	// Upper counter bits pick the tile
	assign tileCol = hCount >> tileShift;
	assign tileRow = vCount >> tileShift;

	// Wraps modulo 2^16 like the memory address bus
	assign memAddress = baseWord + tileCol + tileRow * rowStride;

	// Column in the low bits, row above it
	assign pixelPosNext = {vCount[tileShift-1:0], hCount[tileShift-1:0]};

	// Same edge as the memory read, so offset and glyph stay paired
	always_ff @(posedge clk) begin
		if (reset) begin
			pixelPos <= '0;
			brightDelayed <= 1'b0;
		end else begin
			pixelPos <= pixelPosNext;
			brightDelayed <= bright;
		end
	end

endmodule

`default_nettype wire

// File: verilog/glyphDecoder.sv
// Glyph code classifier
`default_nettype none

module glyphDecoder (
	input wire [bitGenPkg::countWidth-1:0] glyphCode,
	output logic pathGlyph,
	output logic yellowTeam,
	output logic [bitGenPkg::shapeWidth-1:0] pathShape,
	output logic [1:0] solidSelect
);
	import bitGenPkg::*;

	logic inBlueRange;
	logic inYellowRange;
	logic [shapeWidth-1:0] blueOffset;
	logic [shapeWidth-1:0] yellowOffset;

	assign inBlueRange = (glyphCode >= bluePathFirst) && (glyphCode <= bluePathLast);
	assign inYellowRange = (glyphCode >= yellowPathFirst) && (glyphCode <= yellowPathLast);

	// Both ranges hold seven codes, so three bits of offset suffice
	assign blueOffset = shapeWidth'(glyphCode - bluePathFirst);
	assign yellowOffset = shapeWidth'(glyphCode - yellowPathFirst);

	assign pathGlyph = inBlueRange | inYellowRange;
	assign yellowTeam = inYellowRange;

	always_comb begin
		if (inYellowRange) begin
			pathShape = yellowOffset;
		end else if (inBlueRange) begin
			pathShape = blueOffset;
		end else begin
			pathShape = shapeHorizontal;
		end
	end

	// Bike, explosion and unknown codes all fall to black
	always_comb begin
		case (glyphCode)
			glyphBlack: solidSelect = solidBlack;
			glyphBlue: solidSelect = solidBlue;
			glyphYellow: solidSelect = solidYellow;
			glyphWhite: solidSelect = solidWhite;
			default: solidSelect = solidBlack;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/pathMask.sv
// Path glyph edge mask
`default_nettype none

module pathMask (
	input wire [bitGenPkg::shapeWidth-1:0] pathShape,
	input wire [bitGenPkg::pixelPosWidth-1:0] pixelPos,
	output logic onEdge
);
	import bitGenPkg::*;

	// One bit per offset, grouped by row with row 3 leftmost
	// and column 3 leftmost inside each row
	localparam logic [15:0] maskHorizontal = 16'b1111_0000_0000_1111;
	localparam logic [15:0] maskVertical = 16'b1001_1001_1001_1001;
	localparam logic [15:0] maskCorner = 16'b1111_1001_1001_1111;
	localparam logic [15:0] maskLeftDown = 16'b1001_1000_1000_1111;
	localparam logic [15:0] maskLeftUp = 16'b1111_1000_1000_1001;
	localparam logic [15:0] maskRightDown = 16'b1001_0001_0001_1111;
	localparam logic [15:0] maskRightUp = 16'b1111_0001_0001_1001;

	logic [15:0] edgeSet;

	always_comb begin
		case (pathShape)
			shapeHorizontal: edgeSet = maskHorizontal;
			shapeVertical: edgeSet = maskVertical;
			shapeCorner: edgeSet = maskCorner;
			shapeLeftDown: edgeSet = maskLeftDown;
			shapeLeftUp: edgeSet = maskLeftUp;
			shapeRightDown: edgeSet = maskRightDown;
			shapeRightUp: edgeSet = maskRightUp;
			// Index 7 is never decoded
			default: edgeSet = '0;
		endcase
	end

	assign onEdge = edgeSet[pixelPos];

endmodule

`default_nettype wire

// File: verilog/paletteOut.sv
// Colour select and output register
`default_nettype none

module paletteOut (
	input wire clk,
	input wire reset,
	input wire brightDelayed,
	input wire pathGlyph,
	input wire yellowTeam,
	input wire onEdge,
	input wire [1:0] solidSelect,
	output logic [bitGenPkg::colorWidth-1:0] vgaR,
	output logic [bitGenPkg::colorWidth-1:0] vgaG,
	output logic [bitGenPkg::colorWidth-1:0] vgaB
);
	import bitGenPkg::*;

	logic [3*colorWidth-1:0] pathColor;
	logic [3*colorWidth-1:0] solidColor;
	logic [3*colorWidth-1:0] pixelColor;

	// Team picks the hue, the mask picks edge or inner shade
	always_comb begin
		case ({yellowTeam, onEdge})
			2'b00: pathColor = blueInner;
			2'b01: pathColor = blueEdge;
			2'b10: pathColor = yellowInner;
			default: pathColor = yellowEdge;
		endcase
	end

	always_comb begin
		case (solidSelect)
			solidBlue: solidColor = pureBlue;
			solidYellow: solidColor = pureYellow;
			solidWhite: solidColor = white;
			default: solidColor = '0;
		endcase
	end

	assign pixelColor = pathGlyph ? pathColor : solidColor;

	always_ff @(posedge clk) begin
		if (reset) begin
			{vgaR, vgaG, vgaB} <= '0;
		end else if (!brightDelayed) begin
			// Blanking interval
			{vgaR, vgaG, vgaB} <= '0;
		end else begin
			{vgaR, vgaG, vgaB} <= pixelColor;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bitGen.sv
// Tile pixel colour generator
`default_nettype none

module bitGen #(
	parameter int tileMapBase = 40000,
	parameter int tilesPerRow = 160
) (
	input wire clk,
	input wire reset,
	input wire [bitGenPkg::countWidth-1:0] hCount,
	input wire [bitGenPkg::countWidth-1:0] vCount,
	input wire bright,
	input wire [bitGenPkg::countWidth-1:0] memData,
	output wire [bitGenPkg::countWidth-1:0] memAddress,
	output wire [bitGenPkg::colorWidth-1:0] vgaR,
	output wire [bitGenPkg::colorWidth-1:0] vgaG,
	output wire [bitGenPkg::colorWidth-1:0] vgaB
);
	import bitGenPkg::*;

	wire [pixelPosWidth-1:0] pixelPos;
	wire brightDelayed;
	wire pathGlyph;
	wire yellowTeam;
	wire [shapeWidth-1:0] pathShape;
	wire [1:0] solidSelect;
	wire onEdge;

	// Address now, offset and bright one edge later with memData
	tileFetch #(
		.tileMapBase(tileMapBase),
		.tilesPerRow(tilesPerRow)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.memAddress(memAddress),
		.pixelPos(pixelPos),
		.brightDelayed(brightDelayed)
	);

	glyphDecoder decoder0 (
		.glyphCode(memData),
		.pathGlyph(pathGlyph),
		.yellowTeam(yellowTeam),
		.pathShape(pathShape),
		.solidSelect(solidSelect)
	);

	pathMask mask0 (
		.pathShape(pathShape),
		.pixelPos(pixelPos),
		.onEdge(onEdge)
	);

	paletteOut palette0 (
		.clk(clk),
		.reset(reset),
		.brightDelayed(brightDelayed),
		.pathGlyph(pathGlyph),
		.yellowTeam(yellowTeam),
		.onEdge(onEdge),
		.solidSelect(solidSelect),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

endmodule

`default_nettype wire

// File: sim/clockGen.sv
// Testbench clock and reset
`default_nettype none

module clockGen #(
	parameter int period = 10,
	parameter int resetCycles = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Synchronous release on a rising edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/bitGen_props.sv
// Output register properties
`default_nettype none

module paletteOutProps (
	input wire clk,
	input wire reset,
	input wire brightDelayed,
	input wire [bitGenPkg::colorWidth-1:0] vgaR,
	input wire [bitGenPkg::colorWidth-1:0] vgaG,
	input wire [bitGenPkg::colorWidth-1:0] vgaB
);

	wire isBlack;

	assign isBlack = (vgaR == '0) && (vgaG == '0) && (vgaB == '0);

	// Registered outputs clear one edge after reset
	clearedByReset: assert property (@(posedge clk) reset |=> isBlack)
		else $error("colour outputs not cleared after reset");

	// Blanking forces black on the next edge
	blankedWhenDark: assert property (
		@(posedge clk) disable iff (reset) !brightDelayed |=> isBlack
	) else $error("colour outputs not black after blanking");

endmodule

bind paletteOut paletteOutProps props0 (
	.clk(clk),
	.reset(reset),
	.brightDelayed(brightDelayed),
	.vgaR(vgaR),
	.vgaG(vgaG),
	.vgaB(vgaB)
);

`default_nettype wire

// File: sim/bitGenTb.sv
// Bit generator testbench
`default_nettype none

module bitGenTb;
	import bitGenPkg::*;

	localparam int mapBase = 40000;
	localparam int mapStride = 160;
	localparam int resetTimeout = 50;

	wire clk;
	wire reset;
	logic [countWidth-1:0] hCount;
	logic [countWidth-1:0] vCount;
	logic bright;
	logic [countWidth-1:0] memData = '0;
	wire [countWidth-1:0] memAddress;
	wire [colorWidth-1:0] vgaR;
	wire [colorWidth-1:0] vgaG;
	wire [colorWidth-1:0] vgaB;

	// Tile map model where unwritten words read as zero
	logic [countWidth-1:0] tileMem [logic [countWidth-1:0]];

	// Stimulus table with one queue per column
	string names[$];
	logic [countWidth-1:0] hTable[$];
	logic [countWidth-1:0] vTable[$];
	logic brightTable[$];
	logic [countWidth-1:0] glyphTable[$];
	logic [3*colorWidth-1:0] expectTable[$];

	clockGen #(.period(10), .resetCycles(8)) clock0 (.clk(clk), .reset(reset));

	bitGen #(
		.tileMapBase(mapBase),
		.tilesPerRow(mapStride)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.memData(memData),
		.memAddress(memAddress),
		.vgaR(vgaR),
		.vgaG(vgaG),
		.vgaB(vgaB)
	);

	// Synchronous read with one edge of latency
	always @(posedge clk) begin
		if (tileMem.exists(memAddress)) begin
			memData <= tileMem[memAddress];
		end else begin
			memData <= '0;
		end
	end

	function automatic logic [countWidth-1:0] computeAddress(input logic [countWidth-1:0] h,
			input logic [countWidth-1:0] v);
		logic [31:0] full;
		full = 32'(mapBase) + 32'(h >> tileShift) + 32'(v >> tileShift) * 32'(mapStride);
		return full[countWidth-1:0];
	endfunction

	// Edge sets written as rows, columns and lone corner pixels
	function automatic logic pathEdge(input logic [2:0] shape, input logic [3:0] offset);
		logic [1:0] row;
		logic [1:0] col;
		logic result;
		row = offset[3:2];
		col = offset[1:0];
		case (shape)
			3'd0: result = (row == 2'd0) || (row == 2'd3);
			3'd1: result = (col == 2'd0) || (col == 2'd3);
			3'd2: result = !((row == 2'd1 || row == 2'd2) && (col == 2'd1 || col == 2'd2));
			3'd3: result = (row == 2'd0) || (col == 2'd3) || (offset == 4'd12);
			3'd4: result = (row == 2'd3) || (col == 2'd3) || (offset == 4'd0);
			3'd5: result = (row == 2'd0) || (col == 2'd0) || (offset == 4'd15);
			3'd6: result = (row == 2'd3) || (col == 2'd0) || (offset == 4'd3);
			default: result = 1'b0;
		endcase
		return result;
	endfunction

	function automatic logic [23:0] expectedColor(input logic [countWidth-1:0] glyph,
			input logic [3:0] offset, input logic lit);
		logic [23:0] color;
		color = 24'h000000;
		if (lit) begin
			if (glyph >= 16'd3 && glyph <= 16'd9) begin
				color = pathEdge(3'(glyph - 16'd3), offset) ?
					{8'd0, 8'd162, 8'd230} : {8'd156, 8'd219, 8'd230};
			end else if (glyph >= 16'd28 && glyph <= 16'd34) begin
				color = pathEdge(3'(glyph - 16'd28), offset) ?
					{8'd255, 8'd201, 8'd14} : {8'd255, 8'd254, 8'd145};
			end else if (glyph == 16'd1) begin
				color = {8'd0, 8'd0, 8'd255};
			end else if (glyph == 16'd2) begin
				color = {8'd255, 8'd255, 8'd0};
			end else if (glyph == 16'd53) begin
				color = {8'd255, 8'd255, 8'd255};
			end
		end
		return color;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic addEntry(input string name, input logic [countWidth-1:0] h,
			input logic [countWidth-1:0] v, input logic lit, input logic [countWidth-1:0] glyph);
		names.push_back(name);
		hTable.push_back(h);
		vTable.push_back(v);
		brightTable.push_back(lit);
		glyphTable.push_back(glyph);
		expectTable.push_back(expectedColor(glyph, {v[1:0], h[1:0]}, lit));
	endtask

	task automatic buildTable();
		logic [countWidth-1:0] solidCodes [4];
		logic [countWidth-1:0] dropCodes [4];
		logic [countWidth-1:0] tileCol;
		logic [countWidth-1:0] tileRow;
		solidCodes = '{16'd0, 16'd1, 16'd2, 16'd53};
		dropCodes = '{16'd12, 16'd40, 16'd58, 16'd100};
		// Solid squares on random tiles
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 16; off++) begin
				tileCol = 16'($urandom_range(159));
				tileRow = 16'($urandom_range(119));
				addEntry($sformatf("solid%0d_off%0d", solidCodes[s], off),
					{tileCol[13:0], 2'(off)}, {tileRow[13:0], 2'(off >> 2)}, 1'b1, solidCodes[s]);
			end
		end
		for (int code = 3; code <= 34; code++) begin
			if (code <= 9 || code >= 28) begin
				for (int off = 0; off < 16; off++) begin
					addEntry($sformatf("path%0d_off%0d", code, off),
						{14'(code), 2'(off)}, {14'(off + 20), 2'(off >> 2)}, 1'b1, 16'(code));
				end
			end
		end
		for (int d = 0; d < 4; d++) begin
			for (int off = 0; off < 16; off += 5) begin
				addEntry($sformatf("drop%0d_off%0d", dropCodes[d], off),
					{14'(d + 90), 2'(off)}, {14'd7, 2'(off >> 2)}, 1'b1, dropCodes[d]);
			end
		end
		// Every code blanked
		for (int code = 0; code < 64; code++) begin
			addEntry($sformatf("dark%0d", code), {14'(code), 2'(code)},
				{14'd50, 2'(code >> 2)}, 1'b0, 16'(code));
		end
		// Dark entry between two lit ones
		for (int s = 0; s < 4; s++) begin
			addEntry($sformatf("mixLit%0d", s), {14'(s), 2'd1}, 16'd300, 1'b1, solidCodes[s]);
			addEntry($sformatf("mixDark%0d", s), {14'(s), 2'd2}, 16'd301, 1'b0, 16'd30);
			addEntry($sformatf("mixPath%0d", s), {14'(s), 2'd3}, 16'd302, 1'b1, 16'd5);
		end
		addEntry("addrWrap", 16'hFFFF, 16'hFFFF, 1'b1, 16'd2);
		addEntry("addrOrigin", 16'd0, 16'd0, 1'b1, 16'd53);
	endtask

	initial begin
		int waitCycles;
		int entryCount;
		hCount = '0;
		vCount = '0;
		bright = 1'b1;
		void'($urandom(32'hdef4));
		// A lit white tile under the beam while reset is held
		tileMem[computeAddress('0, '0)] = 16'd53;
		buildTable();
		entryCount = names.size();

		waitCycles = 0;
		do begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > resetTimeout) begin
				abortRun("reset was never released");
			end
		end while (reset);

		assert ({vgaR, vgaG, vgaB} === 24'h000000) else
			abortRun($sformatf("mismatch afterReset expected %h actual %h",
				24'h000000, {vgaR, vgaG, vgaB}));

		// Entry k is read at edge k+1 and shows after edge k+2
		for (int k = 0; k < entryCount + 2; k++) begin
			@(posedge clk);
			if (k < entryCount) begin
				hCount <= hTable[k];
				vCount <= vTable[k];
				bright <= brightTable[k];
			end else begin
				bright <= 1'b0;
			end
			@(negedge clk);
			if (k < entryCount) begin
				tileMem[computeAddress(hTable[k], vTable[k])] = glyphTable[k];
				assert (memAddress === computeAddress(hTable[k], vTable[k])) else
					abortRun($sformatf("mismatch %s address expected %h actual %h", names[k],
						computeAddress(hTable[k], vTable[k]), memAddress));
			end
			if (k >= 2) begin
				assert ({vgaR, vgaG, vgaB} === expectTable[k - 2]) else
					abortRun($sformatf("mismatch %s colour expected %h actual %h", names[k - 2],
						expectTable[k - 2], {vgaR, vgaG, vgaB}));
			end
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: bitGen.f
verilog/bitGenPkg.sv
verilog/tileFetch.sv
verilog/glyphDecoder.sv
verilog/pathMask.sv
verilog/paletteOut.sv
verilog/bitGen.sv
sim/clockGen.sv
sim/bitGen_props.sv
sim/bitGenTb.sv

// File: Makefile
# Verilator build and run for the bit generator testbench

VERILATOR ?= verilator
TOP ?= bitGenTb
FILELIST ?= bitGen.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
